// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // ====================
    // Widths and types
    // ====================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10  // LUI result is the immediate
    } alu_op_e;

    // ====================
    // Constants
    // ====================
    localparam logic [2:0] BRANCH_EQ = 3'b000;
    localparam logic [2:0] BRANCH_NE = 3'b001;

    localparam word_t INSTR_NOP = 32'h0000_0013; // addi x0, x0, 0
    localparam word_t PC_STEP   = word_t'(4);

endpackage

`default_nettype wire

// ==== execute/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::word_t   result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = word_t'($signed(a) < $signed(b));
            SLTU:    result = word_t'(a < b);
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = word_t'($signed(a) >>> shamt);
            OR:      result = a | b;
            AND:     result = a & b;
            PASS_B:  result = b;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::word_t instr,
    input  logic          redirect,
    input  rv_pkg::word_t redirect_pc,
    output rv_pkg::word_t pc_addr,
    output rv_pkg::word_t if_pc,
    output rv_pkg::word_t if_instr
);
    import rv_pkg::*;

    // Program counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_addr <= RESET_PC;
        end else if (redirect) begin
            pc_addr <= redirect_pc; // Taken branch or JAL in EX
        end else begin
            pc_addr <= pc_addr + PC_STEP;
        end
    end

    // IF/ID instruction word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_instr <= INSTR_NOP;
        end else begin
            if_instr <= redirect ? INSTR_NOP : instr; // Kill the slot behind EX
        end
    end

    always_ff @(posedge clk) begin
        if_pc <= pc_addr;
    end

endmodule

`default_nettype wire

// ==== decode/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_idx,
    input  rv_pkg::reg_addr_t rs2_idx,
    input  logic              wb_we,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    word_t regs [2**REG_ADDR_W];

    // Write-first read port with x0 tied low
    function automatic word_t read_port(input reg_addr_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wb_we && wb_rd == idx) begin
            return wb_data; // Same-cycle writeback
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx);
        rs2_data = read_port(rs2_idx);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data; // x0 writes dropped
        end
    end

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     if_pc,
    input  rv_pkg::word_t     if_instr,
    input  logic              redirect,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output rv_pkg::reg_addr_t rs1_idx,
    output rv_pkg::reg_addr_t rs2_idx,
    output rv_pkg::word_t     ex_pc,
    output rv_pkg::word_t     ex_rs1_data,
    output rv_pkg::word_t     ex_rs2_data,
    output rv_pkg::word_t     ex_imm,
    output rv_pkg::reg_addr_t ex_rs1,
    output rv_pkg::reg_addr_t ex_rs2,
    output rv_pkg::reg_addr_t ex_rd,
    output rv_pkg::alu_op_e   ex_alu_op,
    output logic              ex_alu_src_imm,
    output logic              ex_reg_write,
    output logic              ex_mem_write,
    output logic              ex_branch,
    output logic              ex_branch_ne,
    output logic              ex_jump
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    word_t      imm;
    alu_op_e    alu_op;
    logic       alu_src_imm;
    logic       reg_write;
    logic       mem_write;
    logic       branch;
    logic       jump;

    // ====================
    // Fields
    // ====================
    assign opcode  = opcode_e'(if_instr[6:0]);
    assign funct3  = if_instr[14:12];
    assign rs1_idx = if_instr[19:15];
    assign rs2_idx = if_instr[24:20];

    // funct3 to ALU op, alt picks SUB or SRA
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    // ====================
    // Control and immediate
    // ====================
    always_comb begin
        alu_op      = ADD;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        imm         = {{20{if_instr[31]}}, if_instr[31:20]}; // I-type
        case (opcode)
            OP: begin
                alu_op    = alu_decode(funct3, if_instr[30]);
                reg_write = 1'b1;
            end
            OP_IMM: begin
                // Bit 30 is immediate except on SRAI
                alu_op      = alu_decode(funct3, if_instr[30] && funct3 == 3'b101);
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            LUI: begin
                alu_op      = PASS_B;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                imm         = {if_instr[31:12], 12'b0};
            end
            STORE: begin
                alu_src_imm = 1'b1;
                mem_write   = (funct3 == 3'b010); // SW only
                imm         = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            end
            BRANCH: begin
                branch = (funct3 == BRANCH_EQ) || (funct3 == BRANCH_NE);
                imm    = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                          if_instr[30:25], if_instr[11:8], 1'b0};
            end
            JAL: begin
                reg_write = 1'b1;
                jump      = 1'b1;
                imm       = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                             if_instr[20], if_instr[30:21], 1'b0};
            end
            default: ; // Unknown opcode decodes to a bubble
        endcase
    end

    // ====================
    // ID/EX
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_reg_write <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_branch    <= 1'b0;
            ex_jump      <= 1'b0;
        end else begin
            // Redirect squashes the instruction now in ID
            ex_reg_write <= reg_write && !redirect;
            ex_mem_write <= mem_write && !redirect;
            ex_branch    <= branch && !redirect;
            ex_jump      <= jump && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc          <= if_pc;
        ex_rs1_data    <= rs1_data;
        ex_rs2_data    <= rs2_data;
        ex_imm         <= imm;
        ex_rs1         <= rs1_idx;
        ex_rs2         <= rs2_idx;
        ex_rd          <= if_instr[11:7];
        ex_alu_op      <= alu_op;
        ex_alu_src_imm <= alu_src_imm;
        ex_branch_ne   <= (funct3 == BRANCH_NE);
    end

    // At most one control transfer per EX slot
    assert property (@(posedge clk) disable iff (!rst_n) !(ex_branch && ex_jump))
        else $error("ID/EX holds a branch and a jump at once");

endmodule

`default_nettype wire

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     ex_pc,
    input  rv_pkg::word_t     ex_rs1_data,
    input  rv_pkg::word_t     ex_rs2_data,
    input  rv_pkg::word_t     ex_imm,
    input  rv_pkg::reg_addr_t ex_rs1,
    input  rv_pkg::reg_addr_t ex_rs2,
    input  rv_pkg::reg_addr_t ex_rd,
    input  rv_pkg::alu_op_e   ex_alu_op,
    input  logic              ex_alu_src_imm,
    input  logic              ex_reg_write,
    input  logic              ex_mem_write,
    input  logic              ex_branch,
    input  logic              ex_branch_ne,
    input  logic              ex_jump,
    input  logic              wb_we,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data,
    output logic              redirect,
    output rv_pkg::word_t     redirect_pc,
    output rv_pkg::word_t     mem_result,
    output rv_pkg::word_t     mem_store_data,
    output rv_pkg::reg_addr_t mem_rd,
    output logic              mem_reg_write,
    output logic              mem_mem_write
);
    import rv_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_out;
    word_t result;
    logic  taken;

    // ====================
    // Forwarding
    // ====================
    function automatic word_t forward(input reg_addr_t src, input word_t id_val);
        if (src != '0 && mem_reg_write && mem_rd == src) begin
            return mem_result; // Producer one slot ahead
        end else if (src != '0 && wb_we && wb_rd == src) begin
            return wb_data;    // Producer two slots ahead
        end
        return id_val;
    endfunction

    always_comb begin
        op_a = forward(ex_rs1, ex_rs1_data);
        op_b = forward(ex_rs2, ex_rs2_data);
    end

    assign alu_b = ex_alu_src_imm ? ex_imm : op_b;

    alu alu_i (
        .a      (op_a),
        .b      (alu_b),
        .op     (ex_alu_op),
        .result (alu_out)
    );

    assign result = ex_jump ? ex_pc + PC_STEP : alu_out; // JAL link address

    // ====================
    // Branch resolution
    // ====================
    assign taken       = ex_branch && ((op_a == op_b) != ex_branch_ne);
    assign redirect    = taken || ex_jump;
    assign redirect_pc = ex_pc + ex_imm; // Same adder for BEQ/BNE and JAL

    // EX/MEM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_reg_write <= 1'b0;
            mem_mem_write <= 1'b0;
        end else begin
            mem_reg_write <= ex_reg_write;
            mem_mem_write <= ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= result;
        mem_store_data <= op_b; // SW data after forwarding
        mem_rd         <= ex_rd;
    end

    // Fetch only ever restarts on a word boundary
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> redirect_pc[1:0] == 2'b00)
        else $error("Misaligned redirect target %h", redirect_pc);

endmodule

`default_nettype wire

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     mem_result,
    input  rv_pkg::word_t     mem_store_data,
    input  rv_pkg::reg_addr_t mem_rd,
    input  logic              mem_reg_write,
    input  logic              mem_mem_write,
    output logic              store_en,
    output rv_pkg::word_t     store_addr,
    output rv_pkg::word_t     store_data,
    output logic              wb_we,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data
);

    // ====================
    // Store port
    // ====================
    assign store_en   = mem_mem_write; // One-cycle strobe, no handshake
    assign store_addr = mem_result;
    assign store_data = mem_store_data;

    // MEM/WB
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_result; // ALU, LUI or link value
    end

    // Word stores only
    assert property (@(posedge clk) disable iff (!rst_n)
        store_en |-> store_addr[1:0] == 2'b00)
        else $error("SW to unaligned address %h", store_addr);

endmodule

`default_nettype wire

// ==== source/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::word_t instr,
    output rv_pkg::word_t pc_addr,
    output logic          store_en,
    output rv_pkg::word_t store_addr,
    output rv_pkg::word_t store_data
);
    import rv_pkg::*;

    // ====================
    // Stage wires
    // ====================
    word_t     if_pc;
    word_t     if_instr;
    reg_addr_t rs1_idx;
    reg_addr_t rs2_idx;
    word_t     rs1_data;
    word_t     rs2_data;

    word_t     ex_pc;
    word_t     ex_rs1_data;
    word_t     ex_rs2_data;
    word_t     ex_imm;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    reg_addr_t ex_rd;
    alu_op_e   ex_alu_op;
    logic      ex_alu_src_imm;
    logic      ex_reg_write;
    logic      ex_mem_write;
    logic      ex_branch;
    logic      ex_branch_ne;
    logic      ex_jump;

    logic      redirect;
    word_t     redirect_pc;

    word_t     mem_result;
    word_t     mem_store_data;
    reg_addr_t mem_rd;
    logic      mem_reg_write;
    logic      mem_mem_write;

    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_i (
        .clk, .rst_n, .instr, .redirect, .redirect_pc,
        .pc_addr, .if_pc, .if_instr
    );

    decode_stage decode_i (
        .clk, .rst_n, .if_pc, .if_instr, .redirect, .rs1_data, .rs2_data,
        .rs1_idx, .rs2_idx,
        .ex_pc, .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_rs1, .ex_rs2, .ex_rd,
        .ex_alu_op, .ex_alu_src_imm, .ex_reg_write, .ex_mem_write,
        .ex_branch, .ex_branch_ne, .ex_jump
    );

    regfile regfile_i (
        .clk, .rst_n, .rs1_idx, .rs2_idx, .wb_we, .wb_rd, .wb_data,
        .rs1_data, .rs2_data
    );

    execute_stage execute_i (
        .clk, .rst_n,
        .ex_pc, .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_rs1, .ex_rs2, .ex_rd,
        .ex_alu_op, .ex_alu_src_imm, .ex_reg_write, .ex_mem_write,
        .ex_branch, .ex_branch_ne, .ex_jump,
        .wb_we, .wb_rd, .wb_data,
        .redirect, .redirect_pc,
        .mem_result, .mem_store_data, .mem_rd, .mem_reg_write, .mem_mem_write
    );

    writeback_stage writeback_i (
        .clk, .rst_n,
        .mem_result, .mem_store_data, .mem_rd, .mem_reg_write, .mem_mem_write,
        .store_en, .store_addr, .store_data,
        .wb_we, .wb_rd, .wb_data
    );

endmodule

`default_nettype wire

// ==== dv/core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_checker #(
    parameter int            PROG_LEN = 16,
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::word_t pc_addr,
    input  logic          store_en,
    input  rv_pkg::word_t store_addr,
    input  rv_pkg::word_t store_data,
    input  rv_pkg::word_t prog [PROG_LEN],
    input  logic          run_done,
    output int            err_count,
    output int            seen_count,
    output int            exp_count,
    output int            missing_count,
    output logic          report_done
);
    import rv_pkg::*;

    word_t exp_addr [$];
    word_t exp_data [$];
    string exp_name [$];
    word_t want_addr;
    word_t want_data;
    string want_name;
    int    errs = 0;
    int    seen = 0;

    assign err_count  = errs;
    assign seen_count = seen;

    // ====================
    // ISA reference
    // ====================
    function automatic word_t isa_op(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Runs the program one instruction at a time and queues every SW
    function automatic void run_reference();
        word_t x [32];
        word_t pc;
        word_t next_pc;
        word_t ins;
        word_t a;
        word_t b;
        int    idx;
        int    steps;
        for (int j = 0; j < 32; j++) begin
            x[j] = '0;
        end
        pc    = RESET_PC;
        idx   = 0;
        steps = 0;
        while (idx >= 0 && idx < PROG_LEN && steps < 4 * PROG_LEN) begin
            ins     = prog[idx];
            a       = x[ins[19:15]];
            b       = x[ins[24:20]];
            next_pc = pc + 32'd4;
            case (ins[6:0])
                7'b0110011: x[ins[11:7]] = isa_op(ins[14:12], ins[30], a, b);
                7'b0010011: x[ins[11:7]] = isa_op(ins[14:12],
                                ins[30] && ins[14:12] == 3'b101, a,
                                {{20{ins[31]}}, ins[31:20]});
                7'b0110111: x[ins[11:7]] = {ins[31:12], 12'b0};
                7'b0100011: begin
                    exp_addr.push_back(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
                    exp_data.push_back(b);
                    exp_name.push_back($sformatf("sw@%h", pc));
                end
                7'b1100011: begin
                    if ((a == b) == (ins[14:12] == 3'b000)) begin // BEQ or BNE taken
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    x[ins[11:7]] = pc + 32'd4;
                    next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                end
                default: ;
            endcase
            x[0]  = '0; // x0 stays zero
            pc    = next_pc;
            idx   = int'((pc - RESET_PC) >> 2);
            steps++;
        end
    endfunction

    // ====================
    // Store comparison
    // ====================
    always @(negedge clk) begin
        if (!rst_n && pc_addr !== RESET_PC) begin
            $display("[FAIL] reset_pc: expected %h, actual %h", RESET_PC, pc_addr);
            errs++;
        end
        if (rst_n && store_en) begin
            seen++;
            if (exp_addr.size() == 0) begin
                $display("ERROR: store to %h with data %h came after the last expected store",
                         store_addr, store_data);
                errs++;
            end else begin
                want_addr = exp_addr.pop_front();
                want_data = exp_data.pop_front();
                want_name = exp_name.pop_front();
                if (store_addr !== want_addr) begin
                    $display("[FAIL] %s addr: expected %h, actual %h",
                             want_name, want_addr, store_addr);
                    errs++;
                end
                if (store_data !== want_data) begin
                    $display("[FAIL] %s data: expected %h, actual %h",
                             want_name, want_data, store_data);
                    errs++;
                end
            end
        end
    end

    initial begin
        report_done   = 1'b0;
        exp_count     = 0;
        missing_count = 0;
        @(posedge rst_n);
        run_reference();
        exp_count = exp_addr.size();
        wait (run_done);
        foreach (exp_addr[k]) begin
            $display("ERROR: expected store %s to %h with data %h never appeared",
                     exp_name[k], exp_addr[k], exp_data[k]);
        end
        missing_count = exp_addr.size();
        report_done   = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;
    import rv_pkg::*;

    localparam word_t RESET_PC = 32'h0000_0100;
    localparam int    BODY_LEN = 96;
    localparam int    PROG_LEN = BODY_LEN + 32;            // Body plus final register dump
    localparam int    TIMEOUT  = 3 * PROG_LEN + 20;
    localparam word_t DONE_PC  = RESET_PC + word_t'(4 * PROG_LEN + 16); // Last SW drained

    logic  clk;
    logic  rst_n;
    word_t instr;
    word_t pc_addr;
    logic  store_en;
    word_t store_addr;
    word_t store_data;

    word_t rom [PROG_LEN];
    int    rom_idx;
    int    seed = 32;
    int    cycles = 0;
    logic  timed_out;
    logic  run_done;
    logic  report_done;
    int    err_count;
    int    seen_count;
    int    exp_count;
    int    missing_count;

    core_top #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clk, .rst_n, .instr, .pc_addr, .store_en, .store_addr, .store_data
    );

    core_checker #(
        .PROG_LEN (PROG_LEN),
        .RESET_PC (RESET_PC)
    ) checker_i (
        .clk, .rst_n, .pc_addr, .store_en, .store_addr, .store_data,
        .prog (rom), .run_done,
        .err_count, .seen_count, .exp_count, .missing_count, .report_done
    );

    // Combinational instruction ROM
    always_comb begin
        rom_idx = int'((pc_addr - RESET_PC) >> 2);
        instr   = (rom_idx >= 0 && rom_idx < PROG_LEN) ? rom[rom_idx] : INSTR_NOP;
    end

    // ====================
    // RV32I encoders
    // ====================
    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], STORE}; // Base is always x0
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    function automatic logic [11:0] store_offset(input word_t r);
        return {1'b0, r[28:20], 2'b00};
    endfunction

    // ====================
    // Program generation
    // ====================
    task automatic build_program();
        word_t      r;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  prev_rd;
        reg_addr_t  prev2_rd;
        logic [2:0] f3;
        logic [6:0] f7;
        int         i;
        int         dump_reg;
        int         r_count;
        i        = 0;
        dump_reg = 0;
        r_count  = 0;
        prev_rd  = '0;
        prev2_rd = '0;
        for (int j = 0; j < PROG_LEN; j++) begin
            rom[j] = INSTR_NOP;
        end
        while (i < BODY_LEN) begin
            r   = $random(seed);
            rd  = {1'b0, r[3:0]};
            rs1 = r[31] ? prev_rd : {1'b0, r[7:4]};   // Often the MEM-distance producer
            rs2 = r[30] ? prev2_rd : {1'b0, r[11:8]}; // Often the WB-distance producer
            f3  = r[14:12];
            if (i % 4 == 3) begin
                rom[i]   = enc_s(store_offset(r), reg_addr_t'(dump_reg)); // Rolling dump
                dump_reg = (dump_reg + 1) % 32;
                i++;
            end else if (r[18:16] >= 3'd6 && i < BODY_LEN - 4) begin
                if (r[16]) begin
                    rom[i] = enc_j(21'(4 * (r[20:19] + 1)), rd);
                end else begin
                    rom[i] = enc_b(13'(4 * (r[20:19] + 1)), r[22] ? rs1 : rs2, rs1,
                                   {2'b00, r[21]});
                end
                // A store right behind must never leak out of a flushed slot
                rom[i + 1] = enc_s(store_offset(r), {1'b0, r[27:24]});
                i += 2;
            end else if (r[18:16] == 3'd5) begin
                rom[i] = {r[31:12], rd, LUI};
                i++;
            end else if (r[18:16] == 3'd4) begin
                rom[i] = enc_s(store_offset(r), rs2);
                i++;
            end else if (r[18:16] <= 3'd1) begin
                // R-type cycles through every funct3 and alternate form
                f3 = 3'(r_count);
                f7 = (r_count[3] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
                rom[i] = enc_r(f7, rs2, rs1, f3, rd);
                r_count++;
                i++;
            end else begin
                f7 = (r[29] && f3 == 3'b101) ? 7'h20 : 7'h00; // SRAI
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    rom[i] = enc_i({f7, r[26:22]}, rs1, f3, rd);
                end else begin
                    rom[i] = enc_i(r[27:16], rs1, f3, rd);
                end
                i++;
            end
            prev2_rd = prev_rd;
            prev_rd  = rd;
        end
        for (int j = 0; j < 32; j++) begin
            rom[BODY_LEN + j] = enc_s(12'(4 * j), reg_addr_t'(j)); // Final register dump
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n     = 1'b0;
        run_done  = 1'b0;
        timed_out = 1'b0;
        build_program();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        while (pc_addr < DONE_PC && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            timed_out = 1'b1;
            $display("ERROR: timeout after %0d cycles, fetch never passed the program end",
                     cycles);
        end
        run_done = 1'b1;
        wait (report_done);
        $display("Stores %0d expected, %0d seen; %0d mismatches, %0d missing, %0d timeouts",
                 exp_count, seen_count, err_count, missing_count, timed_out ? 1 : 0);
        if (!timed_out && err_count == 0 && missing_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
common/rv_pkg.sv
execute/alu.sv
source/fetch_unit.sv
decode/regfile.sv
decode/decode_stage.sv
execute/execute_stage.sv
source/writeback_stage.sv
source/core_top.sv
dv/core_checker.sv
dv/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module core_tb -o core_sim

# Keep the output even if the simulator exits with an error
out=$(./obj_dir/core_sim 2>&1) || true
echo "$out"

# Pass only if the testbench printed the pass line
echo "$out" | grep -qx "TEST PASS"
